// ==== include/memStage_macros.svh ====
`ifndef MEMSTAGE_MACROS_SVH
`define MEMSTAGE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////

// Data memory occupies 0x0000 up to this byte
`define DM_LAST 32'h0000_2FFF

// 12 KiB of 32-bit words
`define DM_WORDS 3072

// Timer blocks, 16-byte aligned
`define TIMER0_BASE 32'h0000_7F00
`define TIMER1_BASE 32'h0000_7F10

//////////////////////////////////////////////////////////////////////
// Register offsets inside one timer
//////////////////////////////////////////////////////////////////////

// Enable in bit 0, interrupt mask in bit 3
`define TIMER_CTRL 32'h0

// Writing here also reloads the counter
`define TIMER_PRESET 32'h4

// Read only
`define TIMER_COUNT 32'h8

`endif

// ==== src/memStagePkg.sv ====
`default_nettype none

package memStagePkg;

	// Memory operation carried with each request
	typedef enum logic [3:0] {
		opNone,
		opLw,
		opLh,
		opLhu,
		opLb,
		opLbu,
		opSw,
		opSh,
		opSb
	} memOpT;

	// Exception code as seen by CP0
	typedef logic [4:0] excCodeT;

	localparam excCodeT excNone = 5'd0;
	localparam excCodeT excAdEL = 5'd4;
	localparam excCodeT excAdES = 5'd5;
	localparam excCodeT excOv   = 5'd12;

	function automatic logic isLoad(input memOpT op);
		return op inside {opLw, opLh, opLhu, opLb, opLbu};
	endfunction

	function automatic logic isStore(input memOpT op);
		return op inside {opSw, opSh, opSb};
	endfunction

endpackage

`default_nettype wire

// ==== src/memErrDetect.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module memErrDetect (
	input  memStagePkg::memOpT   op,
	input  logic [31:0]          addr,
	input  logic                 errIn,
	input  memStagePkg::excCodeT excIn,
	output logic                 err,
	output memStagePkg::excCodeT exc
);
	import memStagePkg::*;

	localparam logic [3:0] countOff = 4'(`TIMER_COUNT);

	logic isLd, isSt, isWord, isHalf;
	logic alignErr, inDm, inTimer0, inTimer1, inTimer;
	logic timerErr, rangeErr, ovErr, addrErr, passEarly;

	assign isLd   = isLoad(op);
	assign isSt   = isStore(op);
	assign isWord = (op == opLw) || (op == opSw);
	assign isHalf = (op == opLh) || (op == opLhu) || (op == opSh);

	// Alignment
	assign alignErr = (isWord && (addr[1:0] != 2'b00)) || (isHalf && addr[0]);

	// Region decode
	assign inDm     = addr <= `DM_LAST;
	assign inTimer0 = (addr >= `TIMER0_BASE) && (addr <= `TIMER0_BASE + `TIMER_COUNT + 32'd3);
	assign inTimer1 = (addr >= `TIMER1_BASE) && (addr <= `TIMER1_BASE + `TIMER_COUNT + 32'd3);
	assign inTimer  = inTimer0 || inTimer1;
	assign rangeErr = !(inDm || inTimer);

	// Timers take only whole words, and count is read only
	assign timerErr = inTimer && (!isWord || (isSt && (addr[3:0] >= countOff)));

	// Execute stage flagged address overflow
	assign ovErr = excIn == excOv;

	assign addrErr = (isLd || isSt) && (alignErr || rangeErr || timerErr || ovErr);

	// An earlier non-overflow error wins over anything found here
	assign passEarly = errIn && !ovErr;

	always_comb begin
		err = errIn;
		exc = excIn;
		if (!passEarly && addrErr) begin
			err = 1'b1;
			exc = isLd ? excAdEL : excAdES;
		end
	end

endmodule

`default_nettype wire

// ==== src/storeAligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module storeAligner (
	input  memStagePkg::memOpT op,
	input  logic [1:0]         addrLow,
	input  logic [31:0]        wData,
	output logic [3:0]         byteEn,
	output logic [31:0]        laneData
);
	import memStagePkg::*;

	always_comb begin
		byteEn   = 4'b0000;
		laneData = wData;
		case (op)
			opSw: begin
				byteEn = 4'b1111;
			end
			opSh: begin
				// Same halfword in both lanes, enable picks one
				laneData = {2{wData[15:0]}};
				byteEn   = addrLow[1] ? 4'b1100 : 4'b0011;
			end
			opSb: begin
				laneData = {4{wData[7:0]}};
				byteEn   = 4'b0001 << addrLow;
			end
			default: begin
				// Loads and bubbles write nothing
				byteEn = 4'b0000;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/loadExtender.sv ====
`timescale 1ns/10ps
`default_nettype none

module loadExtender (
	input  memStagePkg::memOpT op,
	input  logic [1:0]         addrLow,
	input  logic [31:0]        word,
	output logic [31:0]        data
);
	import memStagePkg::*;

	logic [7:0]  byteSel;
	logic [15:0] halfSel;

	// Lane picked by the low address bits
	assign byteSel = word[{addrLow, 3'b000} +: 8];
	assign halfSel = addrLow[1] ? word[31:16] : word[15:0];

	always_comb begin
		case (op)
			opLw:    data = word;
			opLh:    data = {{16{halfSel[15]}}, halfSel};
			opLhu:   data = {16'h0000, halfSel};
			opLb:    data = {{24{byteSel[7]}}, byteSel};
			opLbu:   data = {24'h000000, byteSel};
			// Stores and faulted requests
			default: data = 32'h0000_0000;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/dataMem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module dataMem (
	input  logic        clk,
	input  logic        we,
	input  logic [3:0]  byteEn,
	input  logic [11:0] wordAddr,
	input  logic [31:0] wData,
	output logic [31:0] rData
);

	logic [31:0] mem [`DM_WORDS];

	//////////////////////////////////////////////////////////////////////
	// Byte-lane writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < 4; b++) begin
				if (byteEn[b]) begin
					mem[wordAddr][8*b +: 8] <= wData[8*b +: 8];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered read, old data on a same-edge write
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		rData <= mem[wordAddr];
	end

endmodule

`default_nettype wire

// ==== src/timerRegs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module timerRegs (
	input  logic        clk,
	input  logic        arstN,
	input  logic        we,
	input  logic        sel,
	input  logic [1:0]  regOffset,
	input  logic [31:0] wData,
	output logic [31:0] rData,
	output logic [1:0]  irq
);

	// Word index of each register
	localparam logic [1:0] offCtrl   = 2'(`TIMER_CTRL >> 2);
	localparam logic [1:0] offPreset = 2'(`TIMER_PRESET >> 2);
	localparam logic [1:0] offCount  = 2'(`TIMER_COUNT >> 2);

	logic [31:0] ctrl   [2];
	logic [31:0] preset [2];
	logic [31:0] count  [2];
	logic [1:0]  hit;

	assign hit = we ? (sel ? 2'b10 : 2'b01) : 2'b00;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int t = 0; t < 2; t++) begin
				ctrl[t]   <= '0;
				preset[t] <= '0;
				count[t]  <= '0;
			end
		end else begin
			for (int t = 0; t < 2; t++) begin
				if (hit[t] && (regOffset == offCtrl)) begin
					ctrl[t] <= wData;
				end
				if (hit[t] && (regOffset == offPreset)) begin
					// Reload takes priority over counting
					preset[t] <= wData;
					count[t]  <= wData;
				end else if (ctrl[t][0] && (count[t] != 32'd0)) begin
					count[t] <= count[t] - 32'd1;
				end
			end
		end
	end

	// Interrupt when expired, enabled and allowed by the mask
	always_comb begin
		for (int t = 0; t < 2; t++) begin
			irq[t] = (count[t] == 32'd0) && ctrl[t][0] && ctrl[t][3];
		end
	end

	always_ff @(posedge clk) begin
		case (regOffset)
			offCtrl:   rData <= ctrl[sel];
			offPreset: rData <= preset[sel];
			offCount:  rData <= count[sel];
			default:   rData <= 32'h0000_0000;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/memCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module memCtrl (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 reqValid,
	input  memStagePkg::memOpT   reqOp,
	input  logic [31:0]          reqAddr,
	input  logic                 excErr,
	input  memStagePkg::excCodeT excCode,
	input  logic                 respReady,
	input  logic [31:0]          dmRData,
	input  logic [31:0]          timerRData,
	output logic                 reqReady,
	output logic                 dmWe,
	output logic                 timerWe,
	output logic                 timerSel,
	output logic                 respValid,
	output logic                 respErr,
	output memStagePkg::excCodeT respExc,
	output memStagePkg::memOpT   rdOp,
	output logic [1:0]           rdAddrLow,
	output logic [31:0]          rdWord
);
	import memStagePkg::*;

	localparam logic [31:0] timer1Base = `TIMER1_BASE;

	logic        accept, inDm, storeOk;
	logic        rdTimer, firstCycle;
	logic [31:0] liveWord, heldWord;

	//////////////////////////////////////////////////////////////////////
	// Handshake and write strobes
	//////////////////////////////////////////////////////////////////////

	assign reqReady = !respValid || respReady;
	assign accept   = reqValid && reqReady;

	// Only error-free requests reach here, so anything not in DM is a timer
	assign inDm     = reqAddr <= `DM_LAST;
	assign timerSel = reqAddr[31:4] == timer1Base[31:4];

	assign storeOk = accept && !excErr && isStore(reqOp);
	assign dmWe    = storeOk && inDm;
	assign timerWe = storeOk && !inDm;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			respValid  <= 1'b0;
			firstCycle <= 1'b0;
		end else begin
			firstCycle <= accept;
			if (accept) begin
				respValid <= 1'b1;
			end else if (respReady) begin
				respValid <= 1'b0;
			end
		end
	end

	// Response payload, faulted requests turn into bubbles
	always_ff @(posedge clk) begin
		if (accept) begin
			rdOp      <= excErr ? opNone : reqOp;
			rdAddrLow <= reqAddr[1:0];
			rdTimer   <= !inDm;
			respErr   <= excErr;
			respExc   <= excCode;
		end
		if (firstCycle) begin
			heldWord <= liveWord;
		end
	end

	// Memories read every cycle, so freeze the word while a response waits
	assign liveWord = rdTimer ? timerRData : dmRData;
	assign rdWord   = firstCycle ? liveWord : heldWord;

endmodule

`default_nettype wire

// ==== src/memStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memStage (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 reqValid,
	output logic                 reqReady,
	input  memStagePkg::memOpT   reqOp,
	input  logic [31:0]          reqAddr,
	input  logic [31:0]          reqWData,
	input  logic                 reqErr,
	input  memStagePkg::excCodeT reqExc,
	output logic                 respValid,
	input  logic                 respReady,
	output logic [31:0]          respData,
	output logic                 respErr,
	output memStagePkg::excCodeT respExc,
	output logic [1:0]           timerIrq
);
	import memStagePkg::*;

	logic        excErr;
	excCodeT     excCode;
	logic        dmWe, timerWe, timerSel;
	logic [3:0]  byteEn;
	logic [31:0] laneData, dmRData, timerRData, rdWord;
	memOpT       rdOp;
	logic [1:0]  rdAddrLow;

	memCtrl memCtrl_inst (
		.clk(clk), .arstN(arstN),
		.reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr),
		.excErr(excErr), .excCode(excCode), .respReady(respReady),
		.dmRData(dmRData), .timerRData(timerRData),
		.reqReady(reqReady), .dmWe(dmWe), .timerWe(timerWe), .timerSel(timerSel),
		.respValid(respValid), .respErr(respErr), .respExc(respExc),
		.rdOp(rdOp), .rdAddrLow(rdAddrLow), .rdWord(rdWord)
	);

	memErrDetect memErrDetect_inst (
		.op(reqOp), .addr(reqAddr), .errIn(reqErr), .excIn(reqExc),
		.err(excErr), .exc(excCode)
	);

	storeAligner storeAligner_inst (
		.op(reqOp), .addrLow(reqAddr[1:0]), .wData(reqWData),
		.byteEn(byteEn), .laneData(laneData)
	);

	dataMem dataMem_inst (
		.clk(clk), .we(dmWe), .byteEn(byteEn), .wordAddr(reqAddr[13:2]),
		.wData(laneData), .rData(dmRData)
	);

	// Timers take only sw, so the lane data is the raw word
	timerRegs timerRegs_inst (
		.clk(clk), .arstN(arstN), .we(timerWe), .sel(timerSel),
		.regOffset(reqAddr[3:2]), .wData(laneData),
		.rData(timerRData), .irq(timerIrq)
	);

	loadExtender loadExtender_inst (
		.op(rdOp), .addrLow(rdAddrLow), .word(rdWord), .data(respData)
	);

endmodule

`default_nettype wire

// ==== bench/memStage_props.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module memStageProps (
	input logic                 clk,
	input logic                 arstN,
	input logic                 reqValid,
	input memStagePkg::memOpT   reqOp,
	input logic [31:0]          reqAddr,
	input logic                 reqErr,
	input memStagePkg::excCodeT reqExc,
	input logic                 respValid,
	input logic                 respReady,
	input logic [31:0]          respData,
	input logic                 respErr,
	input memStagePkg::excCodeT respExc,
	input logic                 dmWe
);
	import memStagePkg::*;

	int failCount = 0;

	// No response while the stage is held in reset
	idleInReset: assert property (@(posedge clk) !arstN |-> !respValid)
		else begin
			$error("respValid high during reset");
			failCount++;
		end

	// A stalled response keeps its payload
	holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
		respValid && !respReady |=> respValid && $stable(respData)
			&& $stable(respErr) && $stable(respExc))
		else begin
			$error("response changed while stalled");
			failCount++;
		end

	// Faulting requests never reach the data memory
	noWriteOnFault: assert property (@(posedge clk) disable iff (!arstN)
		dmWe |-> reqValid && !reqErr && (reqExc != excOv) && (reqAddr <= `DM_LAST)
			&& ((reqOp == opSb) || (reqOp == opSh && !reqAddr[0])
			|| (reqOp == opSw && reqAddr[1:0] == 2'b00)))
		else begin
			$error("data memory written by a faulting request");
			failCount++;
		end

endmodule

bind memStage memStageProps propsCheck (
	.clk(clk), .arstN(arstN), .reqValid(reqValid), .reqOp(reqOp),
	.reqAddr(reqAddr), .reqErr(reqErr), .reqExc(reqExc),
	.respValid(respValid), .respReady(respReady),
	.respData(respData), .respErr(respErr), .respExc(respExc),
	.dmWe(dmWe)
);

`default_nettype wire

// ==== bench/memStageTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module memStageTb;
	import memStagePkg::*;

	// Roughly 320 requests, eight cycles each covers heavy back-pressure
	localparam int randOps    = 200;
	localparam int cycleLimit = (randOps + 120) * 8;

	logic        clk, arstN, reqValid, reqReady, reqErr, respValid, respReady, respErr;
	logic        stallOn;
	memOpT       reqOp;
	excCodeT     reqExc, respExc;
	logic [31:0] reqAddr, reqWData, respData;
	logic [1:0]  timerIrq;
	logic [31:0] memModel [`DM_WORDS];
	logic [31:0] ctrlModel [2];
	logic [31:0] presetModel [2];
	logic [38:0] expQ [$];
	string       nameQ [$];
	int          errors, testErrs, checks, passed, testNum, cycles;

	memStage memStage_inst (
		.clk(clk), .arstN(arstN), .reqValid(reqValid), .reqReady(reqReady),
		.reqOp(reqOp), .reqAddr(reqAddr), .reqWData(reqWData), .reqErr(reqErr),
		.reqExc(reqExc), .respValid(respValid), .respReady(respReady),
		.respData(respData), .respErr(respErr), .respExc(respExc), .timerIrq(timerIrq)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Returns {countRead, err, exc, data}; a count read is only bounded by preset
	function automatic logic [38:0] memStageModel(input memOpT op, input logic [31:0] addr,
			input logic [31:0] wd, input logic errIn, input excCodeT excIn);
		logic        ld, st, word, half, inTm, bad, t;
		logic [31:0] w;
		logic [15:0] h;
		logic [7:0]  b;
		ld   = op inside {opLw, opLh, opLhu, opLb, opLbu};
		st   = op inside {opSw, opSh, opSb};
		word = op inside {opLw, opSw};
		half = op inside {opLh, opLhu, opSh};
		t    = (addr & ~32'hF) == `TIMER1_BASE;
		inTm = ((addr & ~32'hF) == `TIMER0_BASE || t) && addr[3:0] < 4'hC;
		bad  = excIn == excOv || !(addr <= `DM_LAST || inTm) || (word && addr[1:0] != 2'd0)
			|| (half && addr[0]) || (inTm && (!word || (st && addr[3:2] == 2'd2)));
		// Earlier errors other than overflow pass through untouched
		if (errIn && excIn != excOv) begin
			return {2'b01, excIn, 32'h0};
		end
		if (bad) begin
			return {2'b01, ld ? excAdEL : excAdES, 32'h0};
		end
		if (st) begin
			if (inTm && addr[3:2] == 2'd0) begin
				ctrlModel[t] = wd;
			end else if (inTm) begin
				presetModel[t] = wd;
			end else if (op == opSw) begin
				memModel[addr[13:2]] = wd;
			end else if (op == opSh) begin
				memModel[addr[13:2]][16*addr[1] +: 16] = wd[15:0];
			end else begin
				memModel[addr[13:2]][8*addr[1:0] +: 8] = wd[7:0];
			end
			return {2'b00, excIn, 32'h0};
		end
		w = !inTm ? memModel[addr[13:2]] : (addr[3:2] == 2'd0) ? ctrlModel[t] : presetModel[t];
		h = w[16*addr[1] +: 16];
		b = w[8*addr[1:0] +: 8];
		case (op)
			opLh:    w = {{16{h[15]}}, h};
			opLhu:   w = {16'h0000, h};
			opLb:    w = {{24{b[7]}}, b};
			opLbu:   w = {24'h000000, b};
			default: w = w;
		endcase
		return {inTm && addr[3:2] == 2'd2, 1'b0, excIn, w};
	endfunction

	// Present one request and hold it until the DUT takes it
	task automatic req(input string name, input memOpT op, input logic [31:0] addr,
			input logic [31:0] wd, input logic errIn = 1'b0, input excCodeT excIn = excNone);
		logic taken;
		expQ.push_back(memStageModel(op, addr, wd, errIn, excIn));
		nameQ.push_back(name);
		reqValid = 1'b1;
		reqOp    = op;
		reqAddr  = addr;
		reqWData = wd;
		reqErr   = errIn;
		reqExc   = excIn;
		do begin
			@(negedge clk);
			taken = reqReady;
			@(posedge clk);
			#2;
		end while (!taken);
		reqValid = 1'b0;
	endtask

	// Wait for outstanding responses, then report the test
	task automatic endTest(input string name);
		while (expQ.size() != 0) begin
			@(posedge clk);
			#2;
		end
		testNum++;
		if (testErrs == 0) begin
			passed++;
		end
		$display("test %0d %s: %s (%0d errors)", testNum, name,
			testErrs == 0 ? "ok" : "failed", testErrs);
		errors += testErrs;
		testErrs = 0;
	endtask

	initial begin : clockGen
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin : watchdog
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, responses stopped arriving", cycleLimit);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : readyDriver
		respReady = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			respReady = stallOn ? 1'($urandom) : 1'b1;
		end
	end

	// Every transferred response against the queue, in order
	initial begin : monitor
		logic [38:0] want;
		logic [37:0] got;
		logic        ok;
		string       name;
		forever begin
			@(negedge clk);
			if (respValid && respReady) begin
				checks++;
				got = {respErr, respExc, respData};
				assert (expQ.size() != 0) else begin
					$display("unexpected response with no request outstanding");
					testErrs++;
				end
				if (expQ.size() != 0) begin
					want = expQ.pop_front();
					name = nameQ.pop_front();
					ok   = want[38] ? (got[37:32] === want[37:32] && respData <= want[31:0])
						: (got === want[37:0]);
					assert (ok) else begin
						$display("mismatch %s: expected %h actual %h", name, want[37:0], got);
						testErrs++;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		logic       irqSeen;
		memOpT      op;
		logic [1:0] off;
		void'($urandom(87));
		reqValid = 1'b0;
		reqOp    = opNone;
		reqAddr  = 32'h0;
		reqWData = 32'h0;
		reqErr   = 1'b0;
		reqExc   = excNone;
		stallOn  = 1'b0;
		ctrlModel   = '{default: '0};
		presetModel = '{default: '0};
		arstN = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		arstN = 1'b1;

		req("sw word", opSw, 32'h40, 32'h8A7B_6C5D);
		req("sw word", opSw, 32'h44, 32'h1234_F0E1);
		req("sh upper", opSh, 32'h46, 32'h0000_C3A5);
		req("sb lane 1", opSb, 32'h45, 32'h0000_0096);
		for (int a = 32'h40; a <= 32'h44; a += 4) begin
			req("lw", opLw, a, 0);
			for (int o = 0; o < 4; o++) begin
				req("lb", opLb, a + o, 0);
				req("lbu", opLbu, a + o, 0);
				if (o[0] == 1'b0) begin
					req("lh", opLh, a + o, 0);
					req("lhu", opLhu, a + o, 0);
				end
			end
		end
		endTest("store then extend");

		req("sw base", opSw, 32'h200, 32'hCAFE_F00D);
		req("sw misaligned", opSw, 32'h201, 32'h1111_1111);
		req("sh misaligned", opSh, 32'h203, 32'h0000_2222);
		req("lw misaligned", opLw, 32'h202, 0);
		req("lh misaligned", opLh, 32'h201, 0);
		req("lhu misaligned", opLhu, 32'h203, 0);
		req("lw unchanged", opLw, 32'h200, 0);
		endTest("misaligned access");

		req("timer1 ctrl", opSw, `TIMER1_BASE + `TIMER_CTRL, 32'h8);
		req("timer1 preset", opSw, `TIMER1_BASE + `TIMER_PRESET, 32'h1234);
		req("lw above dm", opLw, 32'h3000, 0);
		req("sw unmapped", opSw, 32'h4000, 32'h5);
		req("lw timer gap", opLw, `TIMER0_BASE + 32'hC, 0);
		req("lw high", opLw, 32'h8000_0000, 0);
		req("lb timer", opLb, `TIMER0_BASE, 0);
		req("sh timer", opSh, `TIMER1_BASE + `TIMER_PRESET, 32'h77);
		req("sb timer", opSb, `TIMER1_BASE, 32'h1);
		req("sw count", opSw, `TIMER1_BASE + `TIMER_COUNT, 32'h9);
		req("ctrl kept", opLw, `TIMER1_BASE + `TIMER_CTRL, 0);
		req("preset kept", opLw, `TIMER1_BASE + `TIMER_PRESET, 0);
		endTest("range and timer access");

		req("sw seed", opSw, 32'h100, 32'h0BAD_BEEF);
		req("lw overflow", opLw, 32'h100, 0, 1'b1, excOv);
		req("sw overflow", opSw, 32'h100, 32'hFFFF_FFFF, 1'b1, excOv);
		req("sw earlier error", opSw, 32'h100, 32'h1234_5678, 1'b1, 5'd10);
		req("lb earlier error", opLb, 32'h101, 0, 1'b1, 5'd8);
		req("lw unchanged", opLw, 32'h100, 0);
		endTest("incoming errors");

		// Load the counter before enabling so the interrupt waits for expiry
		req("timer0 preset", opSw, `TIMER0_BASE + `TIMER_PRESET, 32'd3);
		req("timer0 ctrl", opSw, `TIMER0_BASE + `TIMER_CTRL, 32'h9);
		req("count bound", opLw, `TIMER0_BASE + `TIMER_COUNT, 0);
		irqSeen = 1'b0;
		for (int c = 0; c < 10 && !irqSeen; c++) begin
			@(negedge clk);
			irqSeen = timerIrq[0];
		end
		@(posedge clk);
		#2;
		assert (irqSeen) else begin
			$display("timer 0 interrupt did not rise within 10 cycles");
			testErrs++;
		end
		// Timer 1 has its mask set but was never enabled
		assert (!timerIrq[1]) else begin
			$display("timer 1 interrupt set while the timer is disabled");
			testErrs++;
		end
		req("ctrl readback", opLw, `TIMER0_BASE + `TIMER_CTRL, 0);
		req("preset readback", opLw, `TIMER0_BASE + `TIMER_PRESET, 0);
		endTest("timer registers");

		stallOn = 1'b1;
		for (int k = 0; k < 32; k++) begin
			req("random fill", opSw, 32'h1000 + 4 * k, $urandom);
		end
		for (int n = 0; n < randOps; n++) begin
			op  = memOpT'(1 + $urandom % 8);
			off = 2'($urandom);
			if (op inside {opLw, opSw}) begin
				off = 2'd0;
			end else if (op inside {opLh, opLhu, opSh}) begin
				off[0] = 1'b0;
			end
			req("random", op, 32'h1000 + 4 * ($urandom % 32) + off, $urandom);
		end
		endTest("random back-pressure");
		stallOn = 1'b0;

		errors += memStage_inst.propsCheck.failCount;
		$display("%0d of %0d tests passed, %0d responses checked, %0d errors",
			passed, testNum, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== memStage.f ====
+incdir+include
src/memStagePkg.sv
src/memErrDetect.sv
src/storeAligner.sv
src/loadExtender.sv
src/dataMem.sv
src/timerRegs.sv
src/memCtrl.sv
src/memStage.sv
bench/memStage_props.sv
bench/memStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module memStageTb \
	-f memStage.f --Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

./obj_dir/VmemStageTb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
